// File: compile.f
design/swarm_cfg_pkg.sv
design/swarm_types_pkg.sv
design/task_issue_fsm.sv
design/thread_alloc_counter.sv
design/rw_read_stage.sv
design/rw_object_mem.sv
design/rw_read_subsys.sv
verif/rw_read_props.sv
verif/rw_read_tb.sv

// File: design/rw_object_mem.sv
`timescale 1ns/1ps
`default_nettype none

module rw_object_mem
   import swarm_cfg_pkg::*;
   import swarm_types_pkg::*;
(
   input  logic        clk,
   input  logic        rstn,
   input  logic        arvalid,
   output logic        arready,
   input  logic [31:0] araddr,
   input  thread_id_t  arid,
   output logic        rvalid,
   input  logic        rready,
   output thread_id_t  rid,
   output line_t       rdata,
   output cache_addr_t rindex
);

   typedef struct packed {
      thread_id_t  id;
      cache_addr_t idx;
   } mem_tag_t;

   line_t    mem [MEM_LINES];
   logic     [MEM_LAT-1:0] pipe_vld;
   mem_tag_t pipe_tag [MEM_LAT];
   mem_tag_t q_tag [RSP_DEPTH];
   logic     [$clog2(RSP_DEPTH)-1:0] wr_ptr;
   logic     [$clog2(RSP_DEPTH)-1:0] rd_ptr;
   logic     [$clog2(RSP_DEPTH+1)-1:0] q_cnt;
   logic     [$clog2(RSP_DEPTH+1)-1:0] used;
   logic     ar_acc;
   logic     push;
   logic     pop;

   initial begin
      $readmemh("rw_init.hex", mem);
   end

   // credit covers reads in the pipe and those already queued.
   assign arready = (used < RSP_DEPTH);
   assign ar_acc  = arvalid && arready;
   assign push    = pipe_vld[MEM_LAT-1];
   assign rvalid  = (q_cnt != '0);
   assign pop     = rvalid && rready;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         pipe_vld <= '0;
      end else begin
         pipe_vld[0] <= ar_acc;
         for (int i = 1; i < MEM_LAT; i++) begin
            pipe_vld[i] <= pipe_vld[i-1];
         end
      end
   end

   always_ff @(posedge clk) begin
      pipe_tag[0] <= '{id: arid, idx: araddr[9:6]};
      for (int i = 1; i < MEM_LAT; i++) begin
         pipe_tag[i] <= pipe_tag[i-1];
      end
      if (push) begin
         q_tag[wr_ptr] <= pipe_tag[MEM_LAT-1];
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         q_cnt  <= '0;
         used   <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         q_cnt <= q_cnt + push - pop;
         used  <= used + ar_acc - pop;   // a read holds its credit until it leaves the queue.
      end
   end

   assign rid    = q_tag[rd_ptr].id;
   assign rindex = q_tag[rd_ptr].idx;
   assign rdata  = mem[q_tag[rd_ptr].idx];

endmodule

`default_nettype wire

// File: design/rw_read_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rw_read_stage
   import swarm_cfg_pkg::*;
   import swarm_types_pkg::*;
(
   input  logic           clk,
   input  logic           rstn,
   input  logic           task_in_valid,
   output logic           task_in_ready,
   input  task_t          task_in,
   input  cq_slice_slot_t cq_slot_in,
   input  thread_id_t     thread_id_in,
   output logic           arvalid,
   input  logic           arready,
   output logic [31:0]    araddr,
   output thread_id_t     arid,
   input  logic           rvalid,
   output logic           rready,
   input  thread_id_t     rid,
   input  line_t          rdata,
   input  cache_addr_t    rindex,
   output logic           task_out_valid,
   input  logic           task_out_ready,
   output rw_write_t      task_out,
   input  reg_req_t       reg_req
);

   task_t          task_desc    [N_THREADS];
   cq_slice_slot_t task_cq_slot [N_THREADS];
   logic [31:0]    base_rw_addr;
   task_t          rsp_task;
   logic [3:0]     word_sel;

   assign arvalid       = task_in_valid;   // the read goes out on the accept cycle.
   assign task_in_ready = arready;
   assign arid          = thread_id_in;
   assign araddr        = base_rw_addr + ({16'd0, task_in.locale} << RW_ARSIZE);

   always_ff @(posedge clk) begin
      if (task_in_valid && task_in_ready) begin
         task_desc[thread_id_in]    <= task_in;
         task_cq_slot[thread_id_in] <= cq_slot_in;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         base_rw_addr <= '0;
      end else if (reg_req.wvalid && (reg_req.waddr == RW_BASE_ADDR)) begin
         base_rw_addr <= {reg_req.wdata[29:0], 2'b00};
      end
   end

   assign rsp_task = task_desc[rid];
   assign word_sel = rsp_task.locale[3:0];   // 16 four-byte words per line.

   always_comb begin
      task_out.task_desc  = rsp_task;
      task_out.cq_slot    = task_cq_slot[rid];
      task_out.thread     = rid;
      task_out.object     = rdata[word_sel*32 +: 32];
      task_out.cache_addr = rindex;
   end

   assign task_out_valid = rvalid;
   assign rready         = task_out_ready;

endmodule

`default_nettype wire

// File: design/rw_read_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module rw_read_subsys
   import swarm_types_pkg::*;
(
   input  logic           clk,
   input  logic           rstn,
   input  logic           task_in_valid,
   output logic           task_in_ready,
   input  task_t          task_in,
   input  cq_slice_slot_t cq_slot_in,
   output logic           task_out_valid,
   input  logic           task_out_ready,
   output rw_write_t      task_out,
   input  reg_req_t       reg_req,
   output reg_rsp_t       reg_rsp
);

   logic        issue_open;
   logic        full;
   logic [2:0]  in_flight;
   thread_id_t  alloc_id;
   logic        stage_valid;
   logic        stage_ready;
   logic        alloc;
   logic        dealloc;
   logic        arvalid;
   logic        arready;
   logic [31:0] araddr;
   thread_id_t  arid;
   logic        rvalid;
   logic        rready;
   thread_id_t  rid;
   line_t       rdata;
   cache_addr_t rindex;

   assign stage_valid   = task_in_valid && issue_open;
   assign task_in_ready = stage_ready && issue_open;
   assign alloc         = stage_valid && stage_ready;
   assign dealloc       = task_out_valid && task_out_ready;

   task_issue_fsm i_fsm (
      .clk        (clk),
      .rstn       (rstn),
      .reg_req    (reg_req),
      .full       (full),
      .in_flight  (in_flight),
      .issue_open (issue_open),
      .reg_rsp    (reg_rsp)
   );

   thread_alloc_counter i_alloc (
      .clk       (clk),
      .rstn      (rstn),
      .alloc     (alloc),
      .dealloc   (dealloc),
      .alloc_id  (alloc_id),
      .in_flight (in_flight),
      .full      (full)
   );

   rw_read_stage i_stage (
      .clk            (clk),
      .rstn           (rstn),
      .task_in_valid  (stage_valid),
      .task_in_ready  (stage_ready),
      .task_in        (task_in),
      .cq_slot_in     (cq_slot_in),
      .thread_id_in   (alloc_id),
      .arvalid        (arvalid),
      .arready        (arready),
      .araddr         (araddr),
      .arid           (arid),
      .rvalid         (rvalid),
      .rready         (rready),
      .rid            (rid),
      .rdata          (rdata),
      .rindex         (rindex),
      .task_out_valid (task_out_valid),
      .task_out_ready (task_out_ready),
      .task_out       (task_out),
      .reg_req        (reg_req)
   );

   rw_object_mem i_mem (
      .clk     (clk),
      .rstn    (rstn),
      .arvalid (arvalid),
      .arready (arready),
      .araddr  (araddr),
      .arid    (arid),
      .rvalid  (rvalid),
      .rready  (rready),
      .rid     (rid),
      .rdata   (rdata),
      .rindex  (rindex)
   );

endmodule

`default_nettype wire

// File: design/swarm_cfg_pkg.sv
`default_nettype none

package swarm_cfg_pkg;

   // thread ids bound the number of tasks in flight.
   localparam int N_THREADS = 4;
   localparam int THREAD_W  = 2;

   // objects are 4 bytes wide.
   localparam int RW_ARSIZE = 2;

   localparam int LINE_BITS = 512;
   localparam int MEM_LINES = 16;

   // object store timing and response buffering.
   localparam int MEM_LAT   = 2;
   localparam int RSP_DEPTH = 4;

   // register map.
   localparam logic [7:0] RW_BASE_ADDR = 8'd0;
   localparam logic [7:0] RW_ENABLE    = 8'd1;
   localparam logic [7:0] RW_STATUS    = 8'd2;

endpackage

`default_nettype wire

// File: design/swarm_types_pkg.sv
`default_nettype none

package swarm_types_pkg;
   import swarm_cfg_pkg::*;

   typedef logic [THREAD_W-1:0]  thread_id_t;
   typedef logic [31:0]          ts_t;
   typedef logic [15:0]          locale_t;
   typedef logic [5:0]           cq_slice_slot_t;
   typedef logic [3:0]           cache_addr_t;   // line index into the object store.
   typedef logic [31:0]          obj_t;
   typedef logic [LINE_BITS-1:0] line_t;
   typedef logic [7:0]           reg_addr_t;
   typedef logic [31:0]          reg_data_t;

   typedef struct packed {
      ts_t         ts;
      locale_t     locale;
      logic [15:0] ttype;
   } task_t;

   // record handed to the write stage.
   typedef struct packed {
      task_t          task_desc;
      cq_slice_slot_t cq_slot;
      thread_id_t     thread;
      obj_t           object;
      cache_addr_t    cache_addr;
   } rw_write_t;

   typedef struct packed {
      logic      wvalid;
      reg_addr_t waddr;
      reg_data_t wdata;
      logic      arvalid;
      reg_addr_t araddr;
   } reg_req_t;

   typedef struct packed {
      logic      rvalid;
      reg_data_t rdata;
   } reg_rsp_t;

   typedef enum logic [1:0] {
      ST_CFG   = 2'd0,
      ST_RUN   = 2'd1,
      ST_DRAIN = 2'd2
   } stage_state_t;

endpackage

`default_nettype wire

// File: design/task_issue_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module task_issue_fsm
   import swarm_cfg_pkg::*;
   import swarm_types_pkg::*;
(
   input  logic       clk,
   input  logic       rstn,
   input  reg_req_t   reg_req,
   input  logic       full,
   input  logic [2:0] in_flight,
   output logic       issue_open,
   output reg_rsp_t   reg_rsp
);

   stage_state_t state;
   stage_state_t state_next;
   logic         enable;
   logic         enable_wr;
   logic         enable_next;
   logic         rsp_valid;
   reg_data_t    rsp_data;
   reg_data_t    status;

   assign enable_wr   = reg_req.wvalid && (reg_req.waddr == RW_ENABLE);
   assign enable_next = enable_wr ? reg_req.wdata[0] : enable;

   always_comb begin
      state_next = state;
      case (state)
         ST_CFG: begin
            if (enable_next) begin
               state_next = ST_RUN;
            end
         end
         ST_RUN: begin
            if (!enable_next) begin
               state_next = ST_DRAIN;   // stop admitting and let the tasks in flight finish.
            end
         end
         ST_DRAIN: begin
            if (in_flight == 3'd0) begin
               state_next = ST_CFG;
            end
         end
         default: state_next = ST_CFG;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state  <= ST_CFG;
         enable <= 1'b0;
      end else begin
         state  <= state_next;
         enable <= enable_next;
      end
   end

   assign issue_open = (state == ST_RUN) && !full;

   assign status = {22'd0, state, 5'd0, in_flight};

   // reads answer one cycle after the request.
   always_ff @(posedge clk) begin
      rsp_data <= (reg_req.araddr == RW_STATUS) ? status : '0;
      if (!rstn) begin
         rsp_valid <= 1'b0;
      end else begin
         rsp_valid <= reg_req.arvalid;
      end
   end

   assign reg_rsp = '{rvalid: rsp_valid, rdata: rsp_data};

endmodule

`default_nettype wire

// File: design/thread_alloc_counter.sv
`timescale 1ns/1ps
`default_nettype none

module thread_alloc_counter
   import swarm_cfg_pkg::*;
   import swarm_types_pkg::*;
(
   input  logic       clk,
   input  logic       rstn,
   input  logic       alloc,
   input  logic       dealloc,
   output thread_id_t alloc_id,
   output logic [2:0] in_flight,
   output logic       full
);

   // ids retire in allocation order, so one wrapping pointer is enough.
   always_ff @(posedge clk) begin
      if (!rstn) begin
         alloc_id <= '0;
      end else if (alloc) begin
         alloc_id <= alloc_id + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         in_flight <= 3'd0;
      end else begin
         case ({alloc, dealloc})
            2'b10:   in_flight <= in_flight + 3'd1;
            2'b01:   in_flight <= in_flight - 3'd1;
            default: in_flight <= in_flight;   // both or neither leave the count alone.
         endcase
      end
   end

   assign full = (in_flight == 3'(N_THREADS));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the read-stage testbench with Verilator and run it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
   --top-module rw_read_tb -o rw_read_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/rw_read_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "=== PASS ==="; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: rw_init.hex
// one 512-bit line per row, line 0 first; word 15 on the left, word 0 on the right
0f5af0c30e5ae0c30d5ad0c30c5ac0c30b5ab0c30a5aa0c3095a90c3085a80c3075a70c3065a60c3055a50c3045a40c3035a30c3025a20c3015a10c3005a00c3
1f5af1c31e5ae1c31d5ad1c31c5ac1c31b5ab1c31a5aa1c3195a91c3185a81c3175a71c3165a61c3155a51c3145a41c3135a31c3125a21c3115a11c3105a01c3
2f5af2c32e5ae2c32d5ad2c32c5ac2c32b5ab2c32a5aa2c3295a92c3285a82c3275a72c3265a62c3255a52c3245a42c3235a32c3225a22c3215a12c3205a02c3
3f5af3c33e5ae3c33d5ad3c33c5ac3c33b5ab3c33a5aa3c3395a93c3385a83c3375a73c3365a63c3355a53c3345a43c3335a33c3325a23c3315a13c3305a03c3
4f5af4c34e5ae4c34d5ad4c34c5ac4c34b5ab4c34a5aa4c3495a94c3485a84c3475a74c3465a64c3455a54c3445a44c3435a34c3425a24c3415a14c3405a04c3
5f5af5c35e5ae5c35d5ad5c35c5ac5c35b5ab5c35a5aa5c3595a95c3585a85c3575a75c3565a65c3555a55c3545a45c3535a35c3525a25c3515a15c3505a05c3
6f5af6c36e5ae6c36d5ad6c36c5ac6c36b5ab6c36a5aa6c3695a96c3685a86c3675a76c3665a66c3655a56c3645a46c3635a36c3625a26c3615a16c3605a06c3
7f5af7c37e5ae7c37d5ad7c37c5ac7c37b5ab7c37a5aa7c3795a97c3785a87c3775a77c3765a67c3755a57c3745a47c3735a37c3725a27c3715a17c3705a07c3
8f5af8c38e5ae8c38d5ad8c38c5ac8c38b5ab8c38a5aa8c3895a98c3885a88c3875a78c3865a68c3855a58c3845a48c3835a38c3825a28c3815a18c3805a08c3
9f5af9c39e5ae9c39d5ad9c39c5ac9c39b5ab9c39a5aa9c3995a99c3985a89c3975a79c3965a69c3955a59c3945a49c3935a39c3925a29c3915a19c3905a09c3
af5afac3ae5aeac3ad5adac3ac5acac3ab5abac3aa5aaac3a95a9ac3a85a8ac3a75a7ac3a65a6ac3a55a5ac3a45a4ac3a35a3ac3a25a2ac3a15a1ac3a05a0ac3
bf5afbc3be5aebc3bd5adbc3bc5acbc3bb5abbc3ba5aabc3b95a9bc3b85a8bc3b75a7bc3b65a6bc3b55a5bc3b45a4bc3b35a3bc3b25a2bc3b15a1bc3b05a0bc3
cf5afcc3ce5aecc3cd5adcc3cc5accc3cb5abcc3ca5aacc3c95a9cc3c85a8cc3c75a7cc3c65a6cc3c55a5cc3c45a4cc3c35a3cc3c25a2cc3c15a1cc3c05a0cc3
df5afdc3de5aedc3dd5addc3dc5acdc3db5abdc3da5aadc3d95a9dc3d85a8dc3d75a7dc3d65a6dc3d55a5dc3d45a4dc3d35a3dc3d25a2dc3d15a1dc3d05a0dc3
ef5afec3ee5aeec3ed5adec3ec5acec3eb5abec3ea5aaec3e95a9ec3e85a8ec3e75a7ec3e65a6ec3e55a5ec3e45a4ec3e35a3ec3e25a2ec3e15a1ec3e05a0ec3
ff5affc3fe5aefc3fd5adfc3fc5acfc3fb5abfc3fa5aafc3f95a9fc3f85a8fc3f75a7fc3f65a6fc3f55a5fc3f45a4fc3f35a3fc3f25a2fc3f15a1fc3f05a0fc3

// File: verif/rw_read_props.sv
`timescale 1ns/1ps
`default_nettype none

module rw_read_props
   import swarm_cfg_pkg::*;
   import swarm_types_pkg::*;
(
   input logic         clk,
   input logic         rstn,
   input logic         task_in_ready,
   input logic         task_out_valid,
   input logic         task_out_ready,
   input rw_write_t    task_out,
   input stage_state_t state,
   input logic [2:0]   in_flight,
   input logic         rvalid
);

   a_ready_only_run: assert property (@(posedge clk) disable iff (!rstn)
      task_in_ready |-> (state == ST_RUN))
      else $error("task_in_ready high while the stage is not running");

   a_in_flight_max: assert property (@(posedge clk) disable iff (!rstn)
      in_flight <= 3'(N_THREADS))
      else $error("in_flight count above the number of thread ids");

   // a stalled record holds still until the write stage takes it.
   a_out_stable: assert property (@(posedge clk) disable iff (!rstn)
      (task_out_valid && !task_out_ready) |=> (task_out_valid && $stable(task_out)))
      else $error("task_out changed while stalled");

   a_rvalid_after_reset: assert property (@(posedge clk)
      $rose(rstn) |-> !rvalid)
      else $error("read response valid in the first cycle out of reset");

endmodule

bind rw_read_subsys rw_read_props i_props (
   .clk            (clk),
   .rstn           (rstn),
   .task_in_ready  (task_in_ready),
   .task_out_valid (task_out_valid),
   .task_out_ready (task_out_ready),
   .task_out       (task_out),
   .state          (i_fsm.state),
   .in_flight      (in_flight),
   .rvalid         (rvalid)
);

`default_nettype wire

// File: verif/rw_read_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rw_read_tb
   import swarm_cfg_pkg::*;
   import swarm_types_pkg::*;
();

   localparam int STIM_CYCLES = 600;
   localparam int CYCLE_LIMIT = 2 * STIM_CYCLES + 200;

   logic           clk;
   logic           rstn;
   logic           task_in_valid;
   logic           task_in_ready;
   task_t          task_in;
   cq_slice_slot_t cq_slot_in;
   logic           task_out_valid;
   logic           task_out_ready;
   rw_write_t      task_out;
   reg_req_t       reg_req;
   reg_rsp_t       reg_rsp;

   line_t          model_mem [MEM_LINES];
   rw_write_t      exp_q [$];
   stage_state_t   m_state;
   int             m_count;
   int             n_acc;
   logic [31:0]    m_base;
   logic           st_pending;
   reg_data_t      st_expected;
   integer         seed;
   int             cycle_cnt;

   rw_read_subsys i_dut (
      .clk            (clk),
      .rstn           (rstn),
      .task_in_valid  (task_in_valid),
      .task_in_ready  (task_in_ready),
      .task_in        (task_in),
      .cq_slot_in     (cq_slot_in),
      .task_out_valid (task_out_valid),
      .task_out_ready (task_out_ready),
      .task_out       (task_out),
      .reg_req        (reg_req),
      .reg_rsp        (reg_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial begin
      cycle_cnt = 0;
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         abort_run();
      end
   end

   task automatic abort_run();
      $display("=== FAIL ===");
      $fatal(1, "testbench stopped on the first error");
   endtask

   task automatic check_record(input string name, input rw_write_t got, input rw_write_t exp);
      if (got !== exp) begin
         $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_status(input string name, input reg_data_t got, input reg_data_t exp);
      if (got !== exp) begin
         $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
         abort_run();
      end
   endtask

   function automatic reg_req_t reg_write_req(input reg_addr_t addr, input reg_data_t data);
      reg_req_t req;
      req        = '0;
      req.wvalid = 1'b1;
      req.waddr  = addr;
      req.wdata  = data;
      return req;
   endfunction

   function automatic reg_req_t reg_read_req(input reg_addr_t addr);
      reg_req_t req;
      req         = '0;
      req.arvalid = 1'b1;
      req.araddr  = addr;
      return req;
   endfunction

   // state code in bits 9:8, tasks in flight in bits 2:0.
   function automatic reg_data_t status_word(input stage_state_t st, input int cnt);
      reg_data_t w;
      w      = '0;
      w[9:8] = st;
      w[2:0] = cnt[2:0];
      return w;
   endfunction

   function automatic rw_write_t expect_record(input task_t t, input cq_slice_slot_t slot,
                                               input int idx);
      rw_write_t   rec;
      logic [31:0] addr;
      addr           = m_base + 32'(t.locale) * 4;
      rec.task_desc  = t;
      rec.cq_slot    = slot;
      rec.thread     = thread_id_t'(idx % N_THREADS);
      rec.cache_addr = addr[9:6];
      rec.object     = model_mem[addr[9:6]][t.locale[3:0]*32 +: 32];
      return rec;
   endfunction

   task automatic run_cycle(input logic offer, input logic ready_rand, input reg_req_t req);
      logic [31:0] r;
      logic        in_fire;
      logic        out_fire;
      logic        en_wr;
      rw_write_t   exp_rec;
      @(negedge clk);
      r              = $random(seed);
      task_in_valid  = offer & r[0];
      task_out_ready = ready_rand ? r[1] : 1'b1;
      task_in.ts     = ts_t'($random(seed));
      task_in.locale = locale_t'($random(seed));
      task_in.ttype  = 16'($random(seed));
      cq_slot_in     = cq_slice_slot_t'($random(seed));
      reg_req        = req;
      #5;   // outputs are settled here and hold until the rising edge.
      check_bit("reg_rsp.rvalid", reg_rsp.rvalid, st_pending);
      if (st_pending) begin
         check_status("reg_rsp.rdata", reg_rsp.rdata, st_expected);
      end
      check_bit("task_in_ready", task_in_ready,
                (m_state == ST_RUN) && (m_count < N_THREADS));
      if (task_out_valid && (exp_q.size() == 0)) begin
         $display("task_out_valid is high with no task outstanding at %0t", $time);
         abort_run();
      end
      in_fire  = task_in_valid && task_in_ready;
      out_fire = task_out_valid && task_out_ready;
      if (out_fire) begin
         exp_rec = exp_q.pop_front();
         check_record("task_out", task_out, exp_rec);
      end
      if (in_fire) begin
         exp_q.push_back(expect_record(task_in, cq_slot_in, n_acc));
         n_acc++;
      end
      st_pending  = req.arvalid;   // the read sees state and count from before this edge.
      st_expected = (req.araddr == RW_STATUS) ? status_word(m_state, m_count) : '0;
      en_wr       = req.wvalid && (req.waddr == RW_ENABLE);
      case (m_state)
         ST_CFG: begin
            if (en_wr && req.wdata[0]) m_state = ST_RUN;
         end
         ST_RUN: begin
            if (en_wr && !req.wdata[0]) m_state = ST_DRAIN;
         end
         default: begin
            if (m_count == 0) m_state = ST_CFG;
         end
      endcase
      m_count = m_count + int'(in_fire) - int'(out_fire);
      if (req.wvalid && (req.waddr == RW_BASE_ADDR)) begin
         m_base = req.wdata << 2;
      end
   endtask

   task automatic traffic(input int n);
      logic [31:0] r;
      for (int i = 0; i < n; i++) begin
         r = $random(seed);
         if (r[2:0] == 3'd0) begin
            run_cycle(1'b1, 1'b1, reg_read_req(RW_STATUS));
         end else begin
            run_cycle(1'b1, 1'b1, '0);
         end
      end
   endtask

   initial begin
      seed           = 32'hd0e;
      rstn           = 1'b0;
      task_in_valid  = 1'b0;
      task_in        = '0;
      cq_slot_in     = '0;
      task_out_ready = 1'b0;
      reg_req        = '0;
      m_state        = ST_CFG;
      m_count        = 0;
      n_acc          = 0;
      m_base         = '0;
      st_pending     = 1'b0;
      st_expected    = '0;
      $readmemh("rw_init.hex", model_mem);
      repeat (10) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;

      // tasks offered before the enable write must not be taken.
      repeat (20) run_cycle(1'b1, 1'b1, '0);
      run_cycle(1'b1, 1'b1, reg_read_req(RW_STATUS));
      run_cycle(1'b0, 1'b1, '0);

      run_cycle(1'b0, 1'b1, reg_write_req(RW_ENABLE, 32'd1));
      traffic(200);
      run_cycle(1'b1, 1'b1, reg_write_req(RW_BASE_ADDR, 32'h40));   // base 0x100, four lines on.
      traffic(150);

      run_cycle(1'b1, 1'b1, reg_write_req(RW_ENABLE, 32'd0));
      while ((m_state != ST_CFG) || (exp_q.size() != 0)) begin
         run_cycle(1'b1, 1'b1, reg_read_req(RW_STATUS));
      end
      run_cycle(1'b0, 1'b1, reg_read_req(RW_STATUS));
      run_cycle(1'b0, 1'b1, '0);

      run_cycle(1'b0, 1'b1, reg_write_req(RW_ENABLE, 32'd1));
      traffic(100);
      while (exp_q.size() != 0) begin
         run_cycle(1'b0, 1'b0, '0);
      end
      run_cycle(1'b0, 1'b0, reg_read_req(RW_STATUS));
      run_cycle(1'b0, 1'b0, '0);

      if ((exp_q.size() != 0) || (n_acc == 0)) begin
         $display("run ended with %0d records missing of %0d accepted tasks",
                  exp_q.size(), n_acc);
         abort_run();
      end else begin
         $display("=== PASS ===");
         $finish;
      end
   end

endmodule

`default_nettype wire
